//--- design/tpu_cfg_pkg.sv
// Geometry and width definitions for the 5x5 weight-stationary matrix engine
// Also holds the lane mask helper shared by the loader and the writer
package tpu_cfg_pkg;

	localparam int DIM       = 5;              // Array side
	localparam int ELEM_W    = 8;              // One matrix element
	localparam int WORD_W    = DIM * ELEM_W;   // Packed row, lane 0 in top byte
	localparam int IDX_W     = 4;              // Memory index
	localparam int DIMSZ_W   = 3;              // m, n and k
	localparam int ARRAY_LAT = 2 * DIM;        // Skew in to deskew out

	typedef logic [ELEM_W-1:0] elem_t;
	typedef logic [WORD_W-1:0] word_t;

	// Keeps lanes below cnt, clears the rest
	function automatic word_t lane_mask(input logic [DIMSZ_W-1:0] cnt);
		word_t mask;
		mask = '0;
		for (int j = 0; j < DIM; j++) begin
			if (j < int'(cnt))
				mask[WORD_W-1-j*ELEM_W -: ELEM_W] = '1;
		end
		return mask;
	endfunction

endpackage

//--- design/tpu_ctrl_pkg.sv
// Control encodings for the matrix engine
// Loader and writer FSM state types
package tpu_ctrl_pkg;

	// Operand sequencer
	typedef enum logic [2:0] {
		IDLE,
		LOAD_W,    // B rows into PE weights
		STREAM_A,  // One A row per cycle
		DRAIN      // Last A read still returning
	} loader_state_e;

	// Output side
	typedef enum logic {
		WAIT_ROWS,
		FINISH     // Done strobe step
	} writer_state_e;

endpackage

//--- design/tile_loader.sv
// Operand loader for the matrix engine
// Latches the job shape on start, reads the five B rows into the PE weight
// strobes, then streams the m rows of A with lanes at or above k cleared.
// Memory data returns one cycle after the index and is registered here.
`timescale 1ns/1ps

module tile_loader import tpu_cfg_pkg::*, tpu_ctrl_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               start_i,
	input  logic [DIMSZ_W-1:0] m_i,
	input  logic [DIMSZ_W-1:0] n_i,
	input  logic [DIMSZ_W-1:0] k_i,
	input  word_t              data_a_i,
	input  word_t              data_b_i,
	output logic [IDX_W-1:0]   index_a_o,
	output logic [IDX_W-1:0]   index_b_o,
	output word_t              weight_row_o,
	output word_t              a_row_o,
	output logic [DIM-1:0]     weight_sel_o,
	output logic               a_valid_o,
	output logic               job_start_o,
	output logic [DIMSZ_W-1:0] m_o,
	output logic [DIMSZ_W-1:0] n_o
);

	loader_state_e      state;
	logic [DIMSZ_W-1:0] m_q, n_q, k_q;
	logic               b_rd_q;    // B data on the bus this cycle
	logic               a_rd_q;    // A data on the bus this cycle
	logic [IDX_W-1:0]   b_idx_q;   // Row number of returning B data
	logic               last_a;

	assign last_a = (index_a_o + IDX_W'(1)) == IDX_W'(m_q);
	assign m_o    = m_q;
	assign n_o    = n_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state       <= IDLE;
			index_a_o   <= '0;
			index_b_o   <= '0;
			m_q         <= '0;
			n_q         <= '0;
			k_q         <= '0;
			job_start_o <= 1'b0;
		end else begin
			job_start_o <= 1'b0;
			case (state)
				IDLE: begin
					if (start_i) begin
						m_q         <= m_i;
						n_q         <= n_i;
						k_q         <= k_i;
						job_start_o <= 1'b1;
						state       <= LOAD_W;
					end
				end
				LOAD_W: begin
					if (index_b_o == IDX_W'(DIM-1))
						state <= STREAM_A;  // index_a_o already at 0
					else
						index_b_o <= index_b_o + IDX_W'(1);
				end
				STREAM_A: begin
					if (last_a) begin
						state     <= DRAIN;
						index_a_o <= '0;
					end else begin
						index_a_o <= index_a_o + IDX_W'(1);
					end
				end
				DRAIN: begin
					state     <= IDLE;
					index_b_o <= '0;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Read return tracking and output strobes
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			b_rd_q       <= 1'b0;
			a_rd_q       <= 1'b0;
			weight_sel_o <= '0;
			a_valid_o    <= 1'b0;
		end else begin
			b_rd_q       <= (state == LOAD_W);
			a_rd_q       <= (state == STREAM_A);
			weight_sel_o <= b_rd_q ? (DIM'(1) << b_idx_q) : '0;
			a_valid_o    <= a_rd_q;
		end
	end

	always_ff @(posedge clk) begin
		b_idx_q      <= index_b_o;
		weight_row_o <= (b_idx_q < IDX_W'(k_q)) ? data_b_i : '0;  // B rows past k load as zero
		a_row_o      <= data_a_i & lane_mask(k_q);
	end

	// Shape must fit the array when a job is taken
	a_shape_ok: assert property (@(posedge clk) disable iff (rst)
		(state == IDLE && start_i) |->
			(m_i >= 1 && m_i <= DIM && n_i >= 1 && n_i <= DIM && k_i >= 1 && k_i <= DIM));

endmodule

//--- design/operand_skew.sv
// Input skew for the systolic array
// Array row r receives A lane r delayed by r cycles, so the partial sums
// meet their operands on the diagonal wavefront. Idle cycles feed zeros.
`timescale 1ns/1ps

module operand_skew import tpu_cfg_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  word_t a_row_i,
	input  logic  a_valid_i,
	output word_t left_o
);

	word_t row_in;

	assign row_in = a_valid_i ? a_row_i : '0;  // Bubbles enter as zeros

	// Row 0 goes straight in
	assign left_o[WORD_W-1 -: ELEM_W] = row_in[WORD_W-1 -: ELEM_W];

	for (genvar r = 1; r < DIM; r++) begin : g_row
		elem_t dl [r];

		always_ff @(posedge clk or posedge rst) begin
			if (rst) begin
				for (int j = 0; j < r; j++)
					dl[j] <= '0;
			end else begin
				dl[0] <= row_in[WORD_W-1-r*ELEM_W -: ELEM_W];
				for (int j = 1; j < r; j++)
					dl[j] <= dl[j-1];
			end
		end

		assign left_o[WORD_W-1-r*ELEM_W -: ELEM_W] = dl[r-1];
	end

endmodule

//--- design/pe.sv
// Processing element of the weight-stationary array
// Holds one B element, passes A to the right and adds its product
// into the column partial sum going down. All arithmetic wraps at 8 bits.
`timescale 1ns/1ps

module pe import tpu_cfg_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  elem_t left_i,
	input  elem_t up_i,
	input  elem_t weight_i,
	input  logic  weight_ld_i,
	output elem_t right_o,
	output elem_t down_o
);

	elem_t weight_q;

	always_ff @(posedge clk) begin
		if (weight_ld_i)
			weight_q <= weight_i;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			right_o <= '0;
			down_o  <= '0;
		end else begin
			right_o <= left_i;
			down_o  <= up_i + left_i * weight_q;  // Modulo 256 MAC
		end
	end

endmodule

//--- design/pe_array.sv
// 5x5 grid of processing elements
// A values flow left to right, partial sums flow top to bottom.
// Row r takes the weight row when its select bit is set.
`timescale 1ns/1ps

module pe_array import tpu_cfg_pkg::*; (
	input  logic           clk,
	input  logic           rst,
	input  word_t          left_i,
	input  word_t          weight_row_i,
	input  logic [DIM-1:0] weight_sel_i,
	output word_t          bottom_o
);

	elem_t h_w [DIM][DIM+1];  // Horizontal links, right edge open
	elem_t v_w [DIM+1][DIM];  // Vertical partial sums

	for (genvar r = 0; r < DIM; r++) begin : g_left
		assign h_w[r][0] = left_i[WORD_W-1-r*ELEM_W -: ELEM_W];
	end

	for (genvar c = 0; c < DIM; c++) begin : g_col
		assign v_w[0][c] = '0;  // Sums start at zero on top
		assign bottom_o[WORD_W-1-c*ELEM_W -: ELEM_W] = v_w[DIM][c];
	end

	for (genvar r = 0; r < DIM; r++) begin : g_r
		for (genvar c = 0; c < DIM; c++) begin : g_c
			pe u_pe (
				.clk         (clk),
				.rst         (rst),
				.left_i      (h_w[r][c]),
				.up_i        (v_w[r][c]),
				.weight_i    (weight_row_i[WORD_W-1-c*ELEM_W -: ELEM_W]),
				.weight_ld_i (weight_sel_i[r]),
				.right_o     (h_w[r][c+1]),
				.down_o      (v_w[r+1][c])
			);
		end
	end

	// Loader addresses one weight row at a time
	a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(weight_sel_i));

endmodule

//--- design/result_deskew.sv
// Output deskew for the systolic array
// Column c leaves the array c cycles after column 0; it is held back by
// DIM-1-c cycles plus an output register so one full row appears at once.
// The valid strobe rides a shift register of the full array latency.
`timescale 1ns/1ps

module result_deskew import tpu_cfg_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  word_t bottom_i,
	input  logic  a_valid_i,
	output word_t row_o,
	output logic  row_valid_o
);

	logic [ARRAY_LAT-1:0] vld_sr;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			vld_sr <= '0;
		else
			vld_sr <= {vld_sr[ARRAY_LAT-2:0], a_valid_i};
	end

	assign row_valid_o = vld_sr[ARRAY_LAT-1];

	for (genvar c = 0; c < DIM; c++) begin : g_col
		elem_t dl [DIM-c];  // Last stage is the output register

		always_ff @(posedge clk or posedge rst) begin
			if (rst) begin
				for (int j = 0; j < DIM - c; j++)
					dl[j] <= '0;
			end else begin
				dl[0] <= bottom_i[WORD_W-1-c*ELEM_W -: ELEM_W];
				for (int j = 1; j < DIM - c; j++)
					dl[j] <= dl[j-1];
			end
		end

		assign row_o[WORD_W-1-c*ELEM_W -: ELEM_W] = dl[DIM-c-1];
	end

endmodule

//--- design/result_writer.sv
// Result writer for the matrix engine
// Clears lanes at or above n, writes row i to output index i one cycle
// after the row arrives, and pulses done after the m-th write.
`timescale 1ns/1ps

module result_writer import tpu_cfg_pkg::*, tpu_ctrl_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               job_start_i,
	input  logic               row_valid_i,
	input  logic [DIMSZ_W-1:0] m_i,
	input  logic [DIMSZ_W-1:0] n_i,
	input  word_t              row_i,
	output logic               wr_en_o,
	output logic               done_o,
	output logic [IDX_W-1:0]   index_o,
	output word_t              data_o
);

	writer_state_e      state;
	logic [DIMSZ_W-1:0] m_q, n_q;
	logic [DIMSZ_W-1:0] row_cnt;  // Rows written this job
	logic               last_row;

	assign last_row = row_valid_i && ((row_cnt + DIMSZ_W'(1)) == m_q);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state   <= WAIT_ROWS;
			m_q     <= '0;
			n_q     <= '0;
			row_cnt <= '0;
			wr_en_o <= 1'b0;
			done_o  <= 1'b0;
			index_o <= '0;
		end else begin
			wr_en_o <= row_valid_i;
			done_o  <= 1'b0;
			if (job_start_i) begin
				m_q     <= m_i;
				n_q     <= n_i;
				row_cnt <= '0;
			end else if (row_valid_i) begin
				row_cnt <= row_cnt + DIMSZ_W'(1);
			end
			if (row_valid_i)
				index_o <= IDX_W'(row_cnt);  // Rows arrive in A order
			case (state)
				WAIT_ROWS: if (last_row) state <= FINISH;
				FINISH: begin
					done_o <= 1'b1;  // Cycle after the last write
					state  <= WAIT_ROWS;
				end
				default: state <= WAIT_ROWS;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (row_valid_i)
			data_o <= row_i & lane_mask(n_q);
	end

	// Array must not emit more rows than the loader streamed
	a_no_extra_rows: assert property (@(posedge clk) disable iff (rst)
		row_valid_i |-> (row_cnt < m_q));

endmodule

//--- design/tpu_top.sv
// Top level of the 5x5 systolic matrix engine, C = A x B
// Loader, input skew, PE grid, output deskew and writer in a
// fixed-latency chain with single-cycle valid strobes.
`timescale 1ns/1ps

module tpu_top import tpu_cfg_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               start_i,
	input  logic [DIMSZ_W-1:0] m_i,
	input  logic [DIMSZ_W-1:0] n_i,
	input  logic [DIMSZ_W-1:0] k_i,
	input  word_t              data_a_i,
	input  word_t              data_b_i,
	output logic [IDX_W-1:0]   index_a_o,
	output logic [IDX_W-1:0]   index_b_o,
	output logic               wr_en_o,
	output logic [IDX_W-1:0]   index_o,
	output word_t              data_o,
	output logic               done_o
);

	word_t              weight_row;
	logic [DIM-1:0]     weight_sel;
	word_t              a_row;
	logic               a_valid;
	word_t              left;
	word_t              bottom;
	word_t              res_row;
	logic               res_valid;
	logic               job_start;
	logic [DIMSZ_W-1:0] job_m, job_n;

	tile_loader u_loader (
		.clk          (clk),
		.rst          (rst),
		.start_i      (start_i),
		.m_i          (m_i),
		.n_i          (n_i),
		.k_i          (k_i),
		.data_a_i     (data_a_i),
		.data_b_i     (data_b_i),
		.index_a_o    (index_a_o),
		.index_b_o    (index_b_o),
		.weight_row_o (weight_row),
		.a_row_o      (a_row),
		.weight_sel_o (weight_sel),
		.a_valid_o    (a_valid),
		.job_start_o  (job_start),
		.m_o          (job_m),
		.n_o          (job_n)
	);

	operand_skew u_skew (
		.clk       (clk),
		.rst       (rst),
		.a_row_i   (a_row),
		.a_valid_i (a_valid),
		.left_o    (left)
	);

	pe_array u_array (
		.clk          (clk),
		.rst          (rst),
		.left_i       (left),
		.weight_row_i (weight_row),
		.weight_sel_i (weight_sel),
		.bottom_o     (bottom)
	);

	// Valid taps the loader strobe and tracks the array latency itself
	result_deskew u_deskew (
		.clk         (clk),
		.rst         (rst),
		.bottom_i    (bottom),
		.a_valid_i   (a_valid),
		.row_o       (res_row),
		.row_valid_o (res_valid)
	);

	result_writer u_writer (
		.clk         (clk),
		.rst         (rst),
		.job_start_i (job_start),
		.row_valid_i (res_valid),
		.m_i         (job_m),
		.n_i         (job_n),
		.row_i       (res_row),
		.wr_en_o     (wr_en_o),
		.done_o      (done_o),
		.index_o     (index_o),
		.data_o      (data_o)
	);

endmodule

//--- tests/tpu_ref.svh
// Reference model for the matrix engine testbench
// Lane access helpers for packed rows and a modulo-256 matmul
`ifndef TPU_REF_SVH
`define TPU_REF_SVH

// Lane 0 sits in the top byte
function automatic elem_t lane_of(input word_t w, input int j);
	return w[WORD_W-1-j*ELEM_W -: ELEM_W];
endfunction

function automatic word_t with_lane(input word_t w, input int j, input elem_t v);
	w[WORD_W-1-j*ELEM_W -: ELEM_W] = v;
	return w;
endfunction

// C rows below m, lanes at or above n stay zero
function automatic void ref_matmul(input word_t a [16], input word_t b [16],
		input int m, input int n, input int k, output word_t c [DIM]);
	int acc;
	for (int i = 0; i < DIM; i++) begin
		c[i] = '0;
		if (i < m) begin
			for (int col = 0; col < n; col++) begin
				acc = 0;
				for (int r = 0; r < k; r++)
					acc += int'(lane_of(a[i], r)) * int'(lane_of(b[r], col));
				c[i] = with_lane(c[i], col, elem_t'(acc & 255));  // Wrap at 8 bits
			end
		end
	end
endfunction

`endif

//--- tests/tb_tpu.sv
// Testbench for the 5x5 systolic matrix engine
// Models both operand memories, runs a set of jobs and checks every
// write against the reference matmul
`timescale 1ns/1ps

module tb_tpu import tpu_cfg_pkg::*; ();

	`include "tpu_ref.svh"

	localparam int          CLK_NS      = 4;
	localparam int          NUM_JOBS    = 17;
	localparam int          JOB_CYCLES  = 5 + DIM + ARRAY_LAT + 10;
	localparam int          WATCHDOG_NS = NUM_JOBS * JOB_CYCLES * CLK_NS + 400;
	localparam logic [31:0] SEED        = 32'habfc_efb6;

	logic               clk, rst, start_i;
	logic [DIMSZ_W-1:0] m_i, n_i, k_i;
	word_t              data_a_i = '0;
	word_t              data_b_i = '0;
	logic [IDX_W-1:0]   index_a_o, index_b_o, index_o;
	logic               wr_en_o, done_o;
	word_t              data_o;

	word_t            mem_a [16];
	word_t            mem_b [16];
	word_t            exp_c [DIM];
	logic [IDX_W-1:0] idx_a_q = '0;
	logic [IDX_W-1:0] idx_b_q = '0;
	logic [31:0]      rng;
	string            cur_test = "idle";
	int               job_m = 0;
	int               wr_cnt = 0;     // Written by the monitor only
	int               wr_seen [DIM] = '{default: 0};
	int               wr_idx;
	int               mon_errs = 0;
	int               chk_errs, tests_pass, tests_fail;

	tpu_top dut_i (
		.clk(clk), .rst(rst), .start_i(start_i), .m_i(m_i), .n_i(n_i), .k_i(k_i),
		.data_a_i(data_a_i), .data_b_i(data_b_i), .index_a_o(index_a_o),
		.index_b_o(index_b_o), .wr_en_o(wr_en_o), .index_o(index_o),
		.data_o(data_o), .done_o(done_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// Synchronous read, data one cycle after the index
	always @(posedge clk) begin
		idx_a_q <= index_a_o;
		idx_b_q <= index_b_o;
	end

	always @(negedge clk) begin
		data_a_i <= mem_a[idx_a_q];
		data_b_i <= mem_b[idx_b_q];
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// High mode keeps every element in 248..255
	function automatic word_t rand_word(input bit high);
		word_t w;
		w = '0;
		for (int j = 0; j < DIM; j++) begin
			rng = xorshift(rng);
			w = with_lane(w, j, high ? (8'hf8 | rng[7:0]) : rng[7:0]);
		end
		return w;
	endfunction

	function automatic int rand_dim();
		rng = xorshift(rng);
		return 1 + int'(rng[7:0] % 8'd5);
	endfunction

	function automatic void fill_mems(input bit high);
		for (int addr = 0; addr < 16; addr++) begin
			mem_a[addr] = rand_word(high);
			mem_b[addr] = rand_word(high);
		end
	endfunction

	// Write checker
	always @(negedge clk) begin
		if (!rst && wr_en_o) begin
			wr_idx = int'(index_o);
			assert (wr_idx < job_m) else begin
				$display("test %s: write to index %0d outside the %0d result rows",
					cur_test, wr_idx, job_m);
				mon_errs++;
			end
			if (wr_idx < DIM) begin
				wr_seen[wr_idx]++;
				assert (data_o === exp_c[wr_idx]) else begin
					$display("MISMATCH test %s row %0d: expected %h actual %h",
						cur_test, wr_idx, exp_c[wr_idx], data_o);
					mon_errs++;
				end
			end
			wr_cnt++;
		end
	end

	task automatic run_job(input string name, input int m, input int n, input int k);
		int errs_before;
		int cnt_before;
		int seen_before [DIM];
		int cycles;
		errs_before = chk_errs + mon_errs;
		cnt_before  = wr_cnt;
		seen_before = wr_seen;
		cur_test    = name;
		job_m       = m;
		ref_matmul(mem_a, mem_b, m, n, k, exp_c);
		@(negedge clk);
		start_i = 1'b1;
		m_i     = DIMSZ_W'(m);
		n_i     = DIMSZ_W'(n);
		k_i     = DIMSZ_W'(k);
		@(negedge clk);
		start_i = 1'b0;
		cycles  = 0;
		while (done_o !== 1'b1 && cycles < JOB_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		assert (done_o === 1'b1) else begin
			$display("test %s: done never pulsed within %0d cycles", name, cycles);
			chk_errs++;
		end
		assert (wr_cnt - cnt_before == m) else begin
			$display("test %s: %0d rows written but %0d expected", name,
				wr_cnt - cnt_before, m);
			chk_errs++;
		end
		for (int i = 0; i < m; i++) begin
			assert (wr_seen[i] - seen_before[i] == 1) else begin
				$display("test %s: row %0d written %0d times", name, i,
					wr_seen[i] - seen_before[i]);
				chk_errs++;
			end
		end
		if (chk_errs + mon_errs == errs_before) begin
			$display("test %s (m=%0d n=%0d k=%0d): pass", name, m, n, k);
			tests_pass++;
		end else begin
			$display("test %s (m=%0d n=%0d k=%0d): FAIL", name, m, n, k);
			tests_fail++;
		end
	endtask

	initial begin
		rst        = 1'b1;
		start_i    = 1'b0;
		m_i        = '0;
		n_i        = '0;
		k_i        = '0;
		rng        = SEED;
		chk_errs   = 0;
		tests_pass = 0;
		tests_fail = 0;
		fill_mems(1'b0);
		repeat (3) @(negedge clk);
		rst = 1'b0;

		// Nothing may come out before a start
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			assert (wr_en_o === 1'b0 && done_o === 1'b0) else begin
				$display("test idle: write enable or done seen before any start");
				chk_errs++;
			end
		end
		$display("test idle: %s", (chk_errs == 0) ? "pass" : "FAIL");
		if (chk_errs == 0)
			tests_pass++;
		else
			tests_fail++;

		for (int r = 0; r < DIM; r++)
			mem_b[r] = with_lane('0, r, 8'd1);  // Identity B
		run_job("identity", DIM, DIM, DIM);

		fill_mems(1'b0);
		run_job("random_full", DIM, DIM, DIM);

		for (int t = 0; t < 6; t++) begin
			fill_mems(1'b0);
			run_job("random_shape", rand_dim(), rand_dim(), rand_dim());
		end

		fill_mems(1'b1);
		run_job("wrap", DIM, DIM, DIM);

		for (int t = 0; t < 8; t++) begin
			fill_mems(1'b0);
			run_job("back_to_back", rand_dim(), rand_dim(), rand_dim());
		end

		$display("%0d tests passed, %0d tests failed, %0d check errors",
			tests_pass, tests_fail, chk_errs + mon_errs);
		if (tests_fail == 0 && chk_errs + mon_errs == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: run did not finish in %0d ns", WATCHDOG_NS);
		$display("sim failed");
		$finish;
	end

endmodule

//--- tb.f
+incdir+tests
design/tpu_cfg_pkg.sv
design/tpu_ctrl_pkg.sv
design/tile_loader.sv
design/operand_skew.sv
design/pe.sv
design/pe_array.sv
design/result_deskew.sv
design/result_writer.sv
design/tpu_top.sv
tests/tb_tpu.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_tpu
FILELIST  := tb.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST)) $(wildcard tests/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Exit status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf $(OBJ_DIR)
